// ==== verilog.f ====
verilog/rv_pkg.sv
verilog/rv_control.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_mul.sv
verilog/rv_exec_top.sv
bench/rv_exec_asserts.sv
bench/rv_exec_tb.sv

// ==== bench/rv_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb import rv_pkg::*;
();

  localparam int n_alu_rand = 120;
  localparam int n_mul_rand = 24;
  localparam int n_instr = 31 + 7 + n_alu_rand + 8 + 64 + n_mul_rand + 18 + 6;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            instr_valid;
  logic [xlen-1:0] instr;
  logic            flush;
  logic            busy;
  logic            illegal;
  wb_s             wb;

  logic [xlen-1:0] shadow [32];        // expected register contents
  logic [31:0]     lfsr = 32'h4e96441a;
  int              cycle = 0;
  int              wb_errors = 0;
  int              ill_errors = 0;
  int              other_errors = 0;
  bit              last_mul = 1'b0;
  logic [19:0]     edge_regs = {5'd7, 5'd10, 5'd8, 5'd5};

  wb_s             exp_q [$];
  int              due_q [$];
  string           name_q [$];

  always #4 clk = ~clk;
  always @(posedge clk) cycle <= cycle + 1;

  rv_exec_top #(
    .mul_step_bits (4)
  ) rv_exec_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .flush       (flush),
    .busy        (busy),
    .illegal     (illegal),
    .wb          (wb)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // loads, stores, branches, jal, csr and bad funct7 codes
  function automatic logic [31:0] illegal_instr(input int i);
    case (i)
      0:       return {12'h004, 5'd5, 3'd2, 5'd9, 7'b0000011};
      1:       return {7'h00, 5'd7, 5'd5, 3'd2, 5'd4, 7'b0100011};
      2:       return {7'h00, 5'd7, 5'd5, 3'd0, 5'd8, 7'b1100011};
      3:       return {12'h300, 5'd5, 3'd1, 5'd9, 7'b1110011};
      4:       return {20'h00010, 5'd1, 7'b1101111};
      5:       return enc_r(7'h10, 3'd0, 5'd9, 5'd5, 5'd7);
      6:       return enc_r(7'h01, 3'd4, 5'd9, 5'd5, 5'd7);   // div
      default: return enc_i(12'h204, 3'd5, 5'd9, 5'd5);
    endcase
  endfunction

  function automatic bit is_legal(input logic [31:0] ins);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = ins[31:25];
    f3 = ins[14:12];
    case (ins[6:0])
      7'b0110011:
        return (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5))
               || ((f7 == 7'h01) && (f3 < 3'd4));
      7'b0010011:
        if (f3 == 3'd1)
          return f7 == 7'h00;
        else if (f3 == 3'd5)
          return (f7 == 7'h00) || (f7 == 7'h20);
        else
          return 1'b1;
      7'b0110111: return 1'b1;
      default:    return 1'b0;
    endcase
  endfunction

  // expected result of one legal instruction
  function automatic logic [31:0] ref_exec(input logic [31:0] ins, input logic [31:0] a,
                                           input logic [31:0] rb);
    logic [31:0] b;
    logic [63:0] p;
    logic [2:0]  f3;
    bit          alt;
    f3  = ins[14:12];
    alt = ins[30];
    b   = (ins[6:0] == 7'b0010011) ? {{20{ins[31]}}, ins[31:20]} : rb;
    if (ins[6:0] == 7'b0110111)
      return {ins[31:12], 12'h000};
    if ((ins[6:0] == 7'b0110011) && ins[25])
    begin
      case (f3[1:0])
        2'd0:    p = {32'h0, a} * {32'h0, b};
        2'd1:    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        2'd2:    p = {{32{a[31]}}, a} * {32'h0, b};
        default: p = {32'h0, a} * {32'h0, b};
      endcase
      return (f3 == 3'd0) ? p[31:0] : p[63:32];
    end
    case (f3)
      3'd0: return (ins[5] && alt) ? a - b : a + b;   // sub only in r-type
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5:
        if (alt)
          return $signed(a) >>> b[4:0];
        else
          return a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_wb(input string name, input wb_s exp, input wb_s act);
    if (act !== exp)
    begin
      wb_errors++;
      $display("[ERROR] %s: expected rd x%0d data %h, actual rd x%0d data %h",
               name, exp.rd, exp.data, act.rd, act.data);
    end
  endtask

  task automatic check_illegal(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      ill_errors++;
      $display("[ERROR] %s: expected illegal %b, actual %b", name, exp, act);
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    flush       = 1'b0;
    last_mul    = 1'b0;
  endtask

  // presents one instruction and returns once it will be consumed next edge
  task automatic run_instr(input string name, input logic [31:0] ins, input logic fl);
    wb_s         exp;
    bit          legal;
    bit          is_mul;
    logic [31:0] val;
    legal  = is_legal(ins);
    is_mul = legal && (ins[6:0] == 7'b0110011) && ins[25];
    if (last_mul)
      go_idle();                       // multiplier rests one cycle
    @(posedge clk);
    #1;
    instr_valid = 1'b1;
    instr       = ins;
    flush       = fl;
    last_mul    = is_mul && !fl;
    if (legal && !fl && (ins[11:7] != 5'd0))
    begin
      val                = ref_exec(ins, shadow[ins[19:15]], shadow[ins[24:20]]);
      shadow[ins[11:7]]  = val;
      exp.valid          = 1'b1;
      exp.rd             = ins[11:7];
      exp.data           = val;
      exp_q.push_back(exp);
      due_q.push_back(cycle + (last_mul ? 9 : 1));
      name_q.push_back(name);
    end
    @(negedge clk);
    check_illegal(name, !legal && !fl, illegal);
    if (last_mul && !busy)
    begin
      other_errors++;
      $display("%s: busy stayed low while the multiply ran", name);
    end
    while (busy)
      @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // writeback compare
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (rst_n && wb.valid)
    begin
      if (exp_q.size() == 0)
      begin
        other_errors++;
        $display("unexpected writeback to x%0d with data %h", wb.rd, wb.data);
      end
      else
      begin
        if (cycle != due_q[0])
        begin
          other_errors++;
          $display("%s: writeback came at cycle %0d instead of cycle %0d",
                   name_q[0], cycle, due_q[0]);
        end
        check_wb(name_q[0], exp_q[0], wb);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        void'(name_q.pop_front());
      end
    end
  end

  initial
  begin
    repeat (5 + n_instr * 12) @(posedge clk);
    $display("run timed out after %0d cycles", 5 + n_instr * 12);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] ins;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [11:0] imm;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    flush       = 1'b0;
    for (int i = 0; i < 32; i++)
      shadow[i] = '0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int r = 1; r < 32; r++)       // xr + xr, all zero after reset
      run_instr("reset_zero", enc_r(7'h00, 3'd0, 5'(r), 5'(r), 5'(r)), 1'b0);

    run_instr("lui", enc_u(20'h80000, 5'd5), 1'b0);             // x5 = min int
    run_instr("addi", enc_i(12'h001, 3'd0, 5'd7, 5'd0), 1'b0);
    run_instr("addi", enc_i(12'hfff, 3'd0, 5'd8, 5'd0), 1'b0);  // x8 = -1
    run_instr("addi", enc_i(12'hfff, 3'd0, 5'd10, 5'd5), 1'b0); // max int
    run_instr("srai_neg", enc_i(12'h404, 3'd5, 5'd6, 5'd5), 1'b0);
    run_instr("srli", enc_i(12'h004, 3'd5, 5'd6, 5'd5), 1'b0);
    run_instr("sub", enc_r(7'h20, 3'd0, 5'd9, 5'd0, 5'd7), 1'b0);

    for (int n = 0; n < n_alu_rand; n++)
    begin
      rd  = 5'd11 + 5'(rand_bits(5) % 21);   // x5..x10 keep edge values
      f3  = 3'(rand_bits(3));
      imm = 12'(rand_bits(12));
      case (rand_bits(2))
        0, 1:
          ins = enc_r(((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1)) ? 7'h20 : 7'h00,
                      f3, rd, 5'(rand_bits(5)), 5'(rand_bits(5)));
        2:
        begin
          if (f3 == 3'd1)
            imm[11:5] = 7'h00;
          else if (f3 == 3'd5)
            imm[11:5] = rand_bits(1) ? 7'h20 : 7'h00;
          ins = enc_i(imm, f3, rd, 5'(rand_bits(5)));
        end
        default: ins = enc_u(20'(rand_bits(20)), rd);
      endcase
      run_instr("alu_rand", ins, 1'b0);
    end

    run_instr("slt", enc_r(7'h00, 3'd2, 5'd9, 5'd5, 5'd7), 1'b0);
    run_instr("sltu", enc_r(7'h00, 3'd3, 5'd9, 5'd5, 5'd7), 1'b0);
    run_instr("slt", enc_r(7'h00, 3'd2, 5'd9, 5'd8, 5'd7), 1'b0);
    run_instr("sltu", enc_r(7'h00, 3'd3, 5'd9, 5'd8, 5'd7), 1'b0);
    run_instr("slt", enc_r(7'h00, 3'd2, 5'd9, 5'd10, 5'd5), 1'b0);
    run_instr("slti", enc_i(12'hfff, 3'd2, 5'd9, 5'd5), 1'b0);
    run_instr("sltiu", enc_i(12'hfff, 3'd3, 5'd9, 5'd7), 1'b0);
    run_instr("sltiu", enc_i(12'h001, 3'd3, 5'd9, 5'd0), 1'b0);

    for (int f = 0; f < 4; f++)
      for (int i = 0; i < 4; i++)
        for (int j = 0; j < 4; j++)
          run_instr("mul_edge", enc_r(7'h01, 3'(f), 5'd12, edge_regs[i*5 +: 5],
                                      edge_regs[j*5 +: 5]), 1'b0);
    for (int n = 0; n < n_mul_rand; n++)
    begin
      rd = 5'd11 + 5'(rand_bits(5) % 21);
      run_instr("mul_rand", enc_r(7'h01, 3'(rand_bits(2)), rd, 5'(rand_bits(5)),
                                  5'(rand_bits(5))), 1'b0);
    end

    for (int fl = 0; fl < 2; fl++)
      for (int i = 0; i < 8; i++)
        run_instr(fl ? "illegal_flush" : "illegal", illegal_instr(i), 1'(fl));
    run_instr("add_flush", enc_r(7'h00, 3'd0, 5'd9, 5'd5, 5'd7), 1'b1);
    run_instr("mul_flush", enc_r(7'h01, 3'd0, 5'd9, 5'd5, 5'd8), 1'b1);

    run_instr("x0_addi", enc_i(12'h07b, 3'd0, 5'd0, 5'd5), 1'b0);
    run_instr("x0_add", enc_r(7'h00, 3'd0, 5'd0, 5'd5, 5'd8), 1'b0);
    run_instr("x0_lui", enc_u(20'hfffff, 5'd0), 1'b0);
    run_instr("x0_mul", enc_r(7'h01, 3'd0, 5'd0, 5'd5, 5'd8), 1'b0);
    run_instr("x0_read", enc_r(7'h00, 3'd0, 5'd9, 5'd0, 5'd0), 1'b0);
    run_instr("x0_read", enc_r(7'h00, 3'd0, 5'd9, 5'd0, 5'd7), 1'b0);
    go_idle();
    repeat (4) @(posedge clk);

    if (exp_q.size() != 0)
    begin
      other_errors += exp_q.size();
      $display("%0d expected writebacks never arrived", exp_q.size());
    end
    $display("errors: writeback %0d, illegal %0d, other %0d",
             wb_errors, ill_errors, other_errors);
    if (wb_errors + ill_errors + other_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/rv_exec_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_asserts import rv_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic busy,
  input logic illegal,
  input wb_s  wb
);

  // x0 writes are never reported
  property no_wb_x0;
    @(posedge clk) disable iff (!rst_n)
      wb.valid |-> (wb.rd != 5'd0);
  endproperty

  // a multiply of 8 steps releases the source in time
  property busy_bounded;
    @(posedge clk) disable iff (!rst_n)
      $rose(busy) |-> ##[1:9] !busy;
  endproperty

  property illegal_no_wb;
    @(posedge clk) disable iff (!rst_n)
      illegal |=> !wb.valid;
  endproperty

  assert property (no_wb_x0)
    else $error("writeback reported for register x0");
  assert property (busy_bounded)
    else $error("busy held for more than 9 cycles");
  assert property (illegal_no_wb)
    else $error("illegal instruction produced a writeback");

endmodule

bind rv_exec_top rv_exec_asserts rv_exec_asserts_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .busy    (busy),
  .illegal (illegal),
  .wb      (wb)
);

`default_nettype wire

// ==== verilog/rv_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top import rv_pkg::*;
#(
  parameter int mul_step_bits = 4
)
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instr_valid,
  input  logic [xlen-1:0] instr,
  input  logic            flush,
  output logic            busy,
  output logic            illegal,
  output wb_s             wb
);

  ctrl_s           ctrl;
  logic            mul_ready;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] mul_result;
  logic [xlen-1:0] wdata;
  logic            we;

  rv_control rv_control_i (
    .instr     (instr),
    .ins_zero  (!instr_valid),
    .flush     (flush),
    .mul_ready (mul_ready),
    .ctrl      (ctrl),
    .busy      (busy),
    .illegal   (illegal)
  );

  rv_regfile rv_regfile_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs1    (ctrl.rs1),
    .rs2    (ctrl.rs2),
    .we     (we),
    .rd     (ctrl.rd),
    .wdata  (wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  rv_alu rv_alu_i (
    .ctrl   (ctrl),
    .a      (rdata1),
    .b      (rdata2),
    .result (alu_result)
  );

  rv_mul #(
    .mul_step_bits (mul_step_bits)
  ) rv_mul_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mul_op    (ctrl.mul_op),
    .a         (rdata1),
    .b         (rdata2),
    .result    (mul_result),
    .mul_ready (mul_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // writeback
  //////////////////////////////////////////////////////////////////////

  assign we    = ctrl.regwrite;
  assign wdata = (ctrl.mul_op != mul_none) ? mul_result : alu_result;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wb.valid <= 1'b0;
    else
      wb.valid <= we && (ctrl.rd != 5'd0);   // x0 writes are not reported
  end

  always_ff @(posedge clk)
  begin
    if (we)
    begin
      wb.rd   <= ctrl.rd;
      wb.data <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_mul import rv_pkg::*;
#(
  parameter int mul_step_bits = 4
)
(
  input  logic            clk,
  input  logic            rst_n,
  input  mul_op_e         mul_op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result,
  output logic            mul_ready
);

  localparam int steps = xlen / mul_step_bits;
  localparam int cnt_w = $clog2(steps + 1);

  typedef enum logic [1:0] {st_idle, st_run, st_done, st_rest} state_e;

  state_e              state;
  logic [cnt_w-1:0]    count;      // steps still to go
  logic [2*xlen-1:0]   acc;
  logic [2*xlen-1:0]   mcand;
  logic [xlen-1:0]     mplier;
  logic                neg_q;
  logic                hi_q;

  logic                sign_a;
  logic                sign_b;
  logic [xlen-1:0]     mag_a;
  logic [xlen-1:0]     mag_b;
  logic [2*xlen-1:0]   step_mcand;
  logic [mul_step_bits-1:0] step_digit;
  logic [2*xlen-1:0]   partial;
  logic [2*xlen-1:0]   prod;

  // operand signedness per form
  assign sign_a = ((mul_op == mul_h) || (mul_op == mul_hsu)) && a[xlen-1];
  assign sign_b = (mul_op == mul_h) && b[xlen-1];
  assign mag_a  = sign_a ? -a : a;
  assign mag_b  = sign_b ? -b : b;

  //////////////////////////////////////////////////////////////////////
  // one shift-add step, the first one taken at the start edge
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    step_mcand = (state == st_idle) ? {{xlen{1'b0}}, mag_a} : mcand;
    step_digit = (state == st_idle) ? mag_b[mul_step_bits-1:0]
                                    : mplier[mul_step_bits-1:0];
    partial = '0;
    for (int i = 0; i < mul_step_bits; i++)
      if (step_digit[i])
        partial = partial + (step_mcand << i);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= st_idle;
      count <= '0;
    end
    else
    begin
      unique case (state)
        st_idle:
          if (mul_op != mul_none)
          begin
            state <= st_run;
            count <= cnt_w'(steps - 1);
          end
        st_run:
          if (mul_op == mul_none)
            state <= st_idle;         // flushed mid-run
          else if (count == cnt_w'(1))
            state <= st_done;
          else
            count <= count - 1'b1;
        st_done: state <= st_rest;    // ready for this cycle only
        st_rest: state <= st_idle;    // skip the held instruction
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk)
  begin
    if ((state == st_idle) && (mul_op != mul_none))
    begin
      acc    <= partial;
      mcand  <= step_mcand << mul_step_bits;
      mplier <= mag_b >> mul_step_bits;
      neg_q  <= sign_a ^ sign_b;
      hi_q   <= (mul_op != mul_lo);
    end
    else if (state == st_run)
    begin
      acc    <= acc + partial;
      mcand  <= mcand << mul_step_bits;
      mplier <= mplier >> mul_step_bits;
    end
  end

  assign prod      = neg_q ? -acc : acc;
  assign result    = hi_q ? prod[2*xlen-1:xlen] : prod[xlen-1:0];
  assign mul_ready = (state == st_done);

endmodule

`default_nettype wire

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*;
(
  input  ctrl_s           ctrl,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            lt_s;
  logic            lt_u;

  // immediate or register operand
  assign op_b  = ctrl.alusrc ? ctrl.imm : b;
  assign shamt = op_b[4:0];

  assign lt_s = $signed(a) < $signed(op_b);
  assign lt_u = a < op_b;

  always_comb
  begin
    result = '0;
    if (ctrl.lui)
    begin
      result = ctrl.imm;            // upper immediate as is
    end
    else if (ctrl.cmp_op == cmp_slt)
    begin
      result = {{(xlen-1){1'b0}}, lt_s};
    end
    else if (ctrl.cmp_op == cmp_sltu)
    begin
      result = {{(xlen-1){1'b0}}, lt_u};
    end
    else
    begin
      unique case (ctrl.alu_op)
        alu_add: result = a + op_b;
        alu_sub: result = a - op_b;
        alu_and: result = a & op_b;
        alu_or:  result = a | op_b;
        alu_xor: result = a ^ op_b;
        alu_sll: result = a << shamt;
        alu_srl: result = a >> shamt;
        alu_sra: result = $signed(a) >>> shamt;  // sign fill
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic            we,
  input  logic [4:0]      rd,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && (rd != 5'd0))   // x0 is hardwired
    begin
      regs[rd] <= wdata;
    end
  end

  // combinational read ports
  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== verilog/rv_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_control import rv_pkg::*;
(
  input  logic [xlen-1:0] instr,
  input  logic            ins_zero,
  input  logic            flush,
  input  logic            mul_ready,
  output ctrl_s           ctrl,
  output logic            busy,
  output logic            illegal
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;

  ctrl_s dec;          // raw decode, before stall gating
  logic  illegal_raw;
  logic  mul_inst;
  logic  stall;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};

  //////////////////////////////////////////////////////////////////////
  // instruction decode
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    dec.alu_op   = alu_add;
    dec.cmp_op   = cmp_none;
    dec.mul_op   = mul_none;
    dec.alusrc   = 1'b0;
    dec.lui      = 1'b0;
    dec.regwrite = 1'b0;
    dec.rd       = instr[11:7];
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.imm      = imm_i;
    illegal_raw  = 1'b0;

    unique case (opcode)
      op_op:                                // register-register
      begin
        dec.regwrite = 1'b1;
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: dec.alu_op = alu_add;
          {7'h20, 3'b000}: dec.alu_op = alu_sub;
          {7'h00, 3'b001}: dec.alu_op = alu_sll;
          {7'h00, 3'b010}: dec.cmp_op = cmp_slt;
          {7'h00, 3'b011}: dec.cmp_op = cmp_sltu;
          {7'h00, 3'b100}: dec.alu_op = alu_xor;
          {7'h00, 3'b101}: dec.alu_op = alu_srl;
          {7'h20, 3'b101}: dec.alu_op = alu_sra;
          {7'h00, 3'b110}: dec.alu_op = alu_or;
          {7'h00, 3'b111}: dec.alu_op = alu_and;
          {7'h01, 3'b000}: dec.mul_op = mul_lo;
          {7'h01, 3'b001}: dec.mul_op = mul_h;
          {7'h01, 3'b010}: dec.mul_op = mul_hsu;
          {7'h01, 3'b011}: dec.mul_op = mul_hu;
          default:         illegal_raw = 1'b1;  // div/rem and bad funct7
        endcase
      end
      op_op_imm:                            // register-immediate
      begin
        dec.regwrite = 1'b1;
        dec.alusrc   = 1'b1;
        unique case (funct3)
          3'b000: dec.alu_op = alu_add;     // addi
          3'b001:                           // slli
            if (funct7 == 7'h00)
              dec.alu_op = alu_sll;
            else
              illegal_raw = 1'b1;
          3'b010: dec.cmp_op = cmp_slt;     // slti
          3'b011: dec.cmp_op = cmp_sltu;    // sltiu
          3'b100: dec.alu_op = alu_xor;     // xori
          3'b101:
            unique case (funct7)
              7'h00:   dec.alu_op  = alu_srl;   // srli
              7'h20:   dec.alu_op  = alu_sra;   // srai
              default: illegal_raw = 1'b1;
            endcase
          3'b110: dec.alu_op = alu_or;      // ori
          3'b111: dec.alu_op = alu_and;     // andi
        endcase
      end
      op_lui:
      begin
        dec.lui      = 1'b1;
        dec.alusrc   = 1'b1;
        dec.imm      = imm_u;
        dec.regwrite = 1'b1;
      end
      // need memory, pc or csr file, none of which live here
      op_load, op_store, op_branch, op_jal, op_jalr, op_auipc, op_system:
        illegal_raw = 1'b1;
      default:
        illegal_raw = 1'b1;
    endcase

    if (illegal_raw)
    begin
      dec.regwrite = 1'b0;
      dec.mul_op   = mul_none;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stall and gating
  //////////////////////////////////////////////////////////////////////

  // only a live, unflushed multiply holds the source
  assign mul_inst = (dec.mul_op != mul_none) && !ins_zero && !flush;
  assign busy     = mul_inst && !mul_ready;
  assign stall    = ins_zero || flush || busy;

  assign illegal = illegal_raw && !ins_zero && !flush;

  always_comb
  begin
    ctrl          = dec;
    ctrl.regwrite = dec.regwrite && !stall;
    if (!mul_inst)
      ctrl.mul_op = mul_none;   // keeps the multiplier idle on empty slots
  end

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_op     = 7'b0110011,
    op_op_imm = 7'b0010011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_system = 7'b1110011
  } opcode_e;

  // same codes as the old alusel field
  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sub = 3'b001,
    alu_and = 3'b010,
    alu_or  = 3'b011,
    alu_xor = 3'b100,
    alu_sll = 3'b101,
    alu_srl = 3'b110,
    alu_sra = 3'b111
  } alu_op_e;

  typedef enum logic [1:0] {
    cmp_none = 2'b00,
    cmp_slt  = 2'b01,
    cmp_sltu = 2'b10
  } cmp_op_e;

  typedef enum logic [2:0] {
    mul_none = 3'b000,
    mul_lo   = 3'b001,
    mul_h    = 3'b010,
    mul_hsu  = 3'b011,
    mul_hu   = 3'b100
  } mul_op_e;

  typedef struct packed {
    alu_op_e         alu_op;
    cmp_op_e         cmp_op;
    mul_op_e         mul_op;
    logic            alusrc;   // operand b is the immediate
    logic            lui;
    logic            regwrite;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;
  } ctrl_s;

  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } wb_s;

endpackage

`default_nettype wire
